/* verilog/fetch_debug_pkg.sv */
package fetch_debug_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Byte program counter, also used for the fetched-instruction counter
    localparam int PC_WIDTH   = 11;
    // Instruction word and debug readout word
    localparam int WORD_WIDTH = 32;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Host commands, sampled when the command strobe is high
    typedef enum logic [3:0] {
        cmd_nop          = 4'd0,
        cmd_run          = 4'd1,
        cmd_halt         = 4'd2,
        cmd_step         = 4'd3,
        cmd_snapshot     = 4'd4,
        cmd_clear        = 4'd5,
        cmd_read_pc      = 4'd6,
        cmd_read_next_pc = 4'd7,
        cmd_read_instr   = 4'd8,
        cmd_read_cycles  = 4'd9
    } debug_cmd_e;

    // Database opcodes, zero keeps the snapshot and the output as they are
    typedef enum logic [2:0] {
        db_hold         = 3'd0,
        db_capture      = 3'd1,
        db_read_pc      = 3'd2,
        db_read_cycles  = 3'd3,
        db_read_next_pc = 3'd4,
        db_read_instr   = 3'd5,
        db_clear        = 3'd6
    } db_op_e;

    // Live fetch state as seen by the debug database
    typedef struct packed {
        logic [PC_WIDTH-1:0]   pc;
        logic [PC_WIDTH-1:0]   next_pc;
        logic [WORD_WIDTH-1:0] instruction;
        logic [PC_WIDTH-1:0]   cycle_count;
    } fetch_state_t;

endpackage

/* verilog/instruction_memory.sv */
`timescale 1ns/1ps

module instruction_memory #(
    parameter int MEM_ADDR_BITS = 9
) (
    input  logic                                  i_clock,
    input  logic                                  i_load_enable,
    input  logic [MEM_ADDR_BITS-1:0]              i_load_addr,
    input  logic [fetch_debug_pkg::WORD_WIDTH-1:0] i_load_data,
    input  logic [fetch_debug_pkg::PC_WIDTH-1:0]   i_pc,
    output logic [fetch_debug_pkg::WORD_WIDTH-1:0] o_instruction
);

    import fetch_debug_pkg::*;

    localparam int DEPTH = 1 << MEM_ADDR_BITS;

    // Program storage, filled by the host while the stage is halted
    logic [WORD_WIDTH-1:0] mem [DEPTH];

    // Word address is the byte PC without its two low bits
    logic [PC_WIDTH-3:0]      word_addr;
    logic [MEM_ADDR_BITS-1:0] read_index;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Load port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge i_clock) begin
        if (i_load_enable) begin
            mem[i_load_addr] <= i_load_data;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fetch port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign word_addr = i_pc[PC_WIDTH-1:2];

    // A memory smaller than the PC range aliases on the low word address bits
    assign read_index = MEM_ADDR_BITS'(word_addr);

    // The instruction follows the PC within the same cycle
    assign o_instruction = mem[read_index];

endmodule

/* verilog/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
    input  logic                                  i_clock,
    input  logic                                  i_soft_reset,
    input  logic                                  i_fetch_enable,
    input  logic [fetch_debug_pkg::WORD_WIDTH-1:0] i_instruction,
    output logic [fetch_debug_pkg::PC_WIDTH-1:0]   o_pc,
    output fetch_debug_pkg::fetch_state_t         o_state
);

    import fetch_debug_pkg::*;

    logic [PC_WIDTH-1:0] pc;
    logic [PC_WIDTH-1:0] next_pc;
    logic [PC_WIDTH-1:0] cycle_count;

    // Without branches or jumps the successor is always the next word
    assign next_pc = pc + PC_WIDTH'(4);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // PC and fetch counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Both registers wrap naturally at 2**PC_WIDTH
    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            pc          <= '0;
            cycle_count <= '0;
        end
        else if (i_fetch_enable) begin
            pc          <= next_pc;
            cycle_count <= cycle_count + 1'b1;
        end
    end

    assign o_pc = pc;

    // Live state bundle for the debug database
    always_comb begin
        o_state             = '0;
        o_state.pc          = pc;
        o_state.next_pc     = next_pc;
        o_state.instruction = i_instruction;
        o_state.cycle_count = cycle_count;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The PC only ever moves in whole words from a word-aligned reset value
    a_pc_word_aligned: assert property (
        @(posedge i_clock) disable iff (!i_soft_reset)
        pc[1:0] == 2'b00
    ) else $error("fetch PC is not word aligned: %0h", pc);

endmodule

/* verilog/debug_controller.sv */
`timescale 1ns/1ps

module debug_controller (
    input  logic                        i_clock,
    input  logic                        i_soft_reset,
    input  logic                        i_command_valid,
    input  fetch_debug_pkg::debug_cmd_e i_command,
    input  logic                        i_load_enable,
    output logic                        o_fetch_enable,
    output fetch_debug_pkg::db_op_e     o_db_op
);

    import fetch_debug_pkg::*;

    // Free-running fetch level, set by run and cleared by halt
    logic running;
    // One-shot request for a single fetch while halted
    logic step_pending;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Run control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            running      <= 1'b0;
            step_pending <= 1'b0;
        end
        else begin
            // The step flag lives for exactly one cycle unless re-armed
            step_pending <= 1'b0;
            if (i_command_valid) begin
                case (i_command)
                    cmd_run:  running <= 1'b1;
                    cmd_halt: running <= 1'b0;
                    // Ignored while running, the stage is already fetching
                    cmd_step: step_pending <= !running;
                    default:  running <= running;
                endcase
            end
        end
    end

    assign o_fetch_enable = running | step_pending;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Database opcode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Registered at the command edge and back to hold on the following one
    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            o_db_op <= db_hold;
        end
        else if (i_command_valid) begin
            case (i_command)
                cmd_snapshot:     o_db_op <= db_capture;
                cmd_clear:        o_db_op <= db_clear;
                cmd_read_pc:      o_db_op <= db_read_pc;
                cmd_read_next_pc: o_db_op <= db_read_next_pc;
                cmd_read_instr:   o_db_op <= db_read_instr;
                cmd_read_cycles:  o_db_op <= db_read_cycles;
                default:          o_db_op <= db_hold;
            endcase
        end
        else begin
            o_db_op <= db_hold;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The memory may only be reprogrammed while the fetch stage is halted
    a_no_load_while_running: assert property (
        @(posedge i_clock) disable iff (!i_soft_reset)
        i_load_enable |-> !running
    ) else $error("instruction memory loaded while the stage is running");

    // A pending step never overlaps free running, so no fetch is counted twice
    a_step_only_when_halted: assert property (
        @(posedge i_clock) disable iff (!i_soft_reset)
        !(step_pending && running)
    ) else $error("step flag set while the stage is running");

endmodule

/* verilog/fetch_database.sv */
`timescale 1ns/1ps

module fetch_database (
    input  logic                                  i_clock,
    input  logic                                  i_soft_reset,
    input  fetch_debug_pkg::db_op_e               i_db_op,
    input  fetch_debug_pkg::fetch_state_t         i_state,
    output logic [fetch_debug_pkg::WORD_WIDTH-1:0] o_data,
    output logic                                  o_data_valid
);

    import fetch_debug_pkg::*;

    // Empty snapshot, the successor of PC zero is the next word
    localparam fetch_state_t CLEAR_STATE = '{
        pc:          '0,
        next_pc:     PC_WIDTH'(4),
        instruction: '0,
        cycle_count: '0
    };

    fetch_state_t snapshot;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Snapshot and readout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            snapshot     <= CLEAR_STATE;
            o_data       <= '0;
            o_data_valid <= 1'b0;
        end
        else begin
            // Valid is a pulse, only a read cycle raises it
            o_data_valid <= 1'b0;
            case (i_db_op)
                db_capture: begin
                    // The last read result stays on the output
                    snapshot <= i_state;
                end
                db_read_pc: begin
                    o_data       <= WORD_WIDTH'(snapshot.pc);
                    o_data_valid <= 1'b1;
                end
                db_read_next_pc: begin
                    o_data       <= WORD_WIDTH'(snapshot.next_pc);
                    o_data_valid <= 1'b1;
                end
                db_read_instr: begin
                    o_data       <= snapshot.instruction;
                    o_data_valid <= 1'b1;
                end
                db_read_cycles: begin
                    o_data       <= WORD_WIDTH'(snapshot.cycle_count);
                    o_data_valid <= 1'b1;
                end
                db_clear: begin
                    snapshot <= CLEAR_STATE;
                    o_data   <= '0;
                end
                // Hold, and the unused opcode, keep everything
                default: begin
                    snapshot <= snapshot;
                    o_data   <= o_data;
                end
            endcase
        end
    end

endmodule

/* verilog/fetch_debug_top.sv */
`timescale 1ns/1ps

module fetch_debug_top #(
    parameter int MEM_ADDR_BITS = 9
) (
    input  logic                                  i_clock,
    input  logic                                  i_soft_reset,
    input  logic                                  i_command_valid,
    input  fetch_debug_pkg::debug_cmd_e           i_command,
    input  logic                                  i_load_enable,
    input  logic [MEM_ADDR_BITS-1:0]              i_load_addr,
    input  logic [fetch_debug_pkg::WORD_WIDTH-1:0] i_load_data,
    output logic [fetch_debug_pkg::WORD_WIDTH-1:0] o_debug_data,
    output logic                                  o_debug_valid
);

    import fetch_debug_pkg::*;

    logic                  fetch_enable;
    db_op_e                db_op;
    logic [PC_WIDTH-1:0]   pc;
    logic [WORD_WIDTH-1:0] instruction;
    fetch_state_t          fetch_state;

    debug_controller u_debug_controller (
        .i_clock         (i_clock),
        .i_soft_reset    (i_soft_reset),
        .i_command_valid (i_command_valid),
        .i_command       (i_command),
        .i_load_enable   (i_load_enable),
        .o_fetch_enable  (fetch_enable),
        .o_db_op         (db_op)
    );

    fetch_stage u_fetch_stage (
        .i_clock        (i_clock),
        .i_soft_reset   (i_soft_reset),
        .i_fetch_enable (fetch_enable),
        .i_instruction  (instruction),
        .o_pc           (pc),
        .o_state        (fetch_state)
    );

    instruction_memory #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) u_instruction_memory (
        .i_clock       (i_clock),
        .i_load_enable (i_load_enable),
        .i_load_addr   (i_load_addr),
        .i_load_data   (i_load_data),
        .i_pc          (pc),
        .o_instruction (instruction)
    );

    fetch_database u_fetch_database (
        .i_clock      (i_clock),
        .i_soft_reset (i_soft_reset),
        .i_db_op      (db_op),
        .i_state      (fetch_state),
        .o_data       (o_debug_data),
        .o_data_valid (o_debug_valid)
    );

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int CLOCK_PERIOD = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic o_clock,
    output logic o_soft_reset
);

    initial begin
        o_clock = 1'b0;
        forever begin
            #(CLOCK_PERIOD / 2);
            o_clock = ~o_clock;
        end
    end

    // Reset is released on a falling edge, half a cycle away from the sampling edge
    initial begin
        o_soft_reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clock);
        @(negedge o_clock);
        o_soft_reset = 1'b1;
    end

endmodule

/* tb/fetch_debug_tb.sv */
`timescale 1ns/1ps

module fetch_debug_tb;

    import fetch_debug_pkg::*;

    localparam int MEM_ADDR_BITS = 9;
    localparam int MEM_DEPTH     = 1 << MEM_ADDR_BITS;
    localparam int CLOCK_PERIOD  = 20;
    localparam int RESET_CYCLES  = 10;
    localparam int MAX_RUN       = 40;
    localparam int MAX_STEPS     = 8;
    localparam int RANDOM_OPS    = 300;
    // Worst case length of the whole sequence including the fixed part of each test
    localparam int TEST_CYCLES   = MEM_DEPTH + MAX_STEPS + 3 * MAX_RUN + 6 * 32
                                   + RANDOM_OPS * 8;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES * 2 + RESET_CYCLES;

    logic                     clock;
    logic                     soft_reset;
    logic                     command_valid;
    debug_cmd_e               command;
    logic                     load_enable;
    logic [MEM_ADDR_BITS-1:0] load_addr;
    logic [WORD_WIDTH-1:0]    load_data;
    logic [WORD_WIDTH-1:0]    debug_data;
    logic                     debug_valid;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [WORD_WIDTH-1:0] model_mem [MEM_DEPTH];
    logic [PC_WIDTH-1:0]   model_pc;
    logic [PC_WIDTH-1:0]   model_count;
    logic                  model_running;
    logic                  model_step;
    db_op_e                model_db_op;
    fetch_state_t          model_snapshot;
    // Value the data output holds between reads
    logic [WORD_WIDTH-1:0] model_data;
    logic [WORD_WIDTH-1:0] expected_reads [$];

    integer seed;
    string  current_test;
    int     test_errors;
    int     total_errors;
    int     tests_run;
    int     tests_failed;
    int     checks_done;
    int     read_pulses;

    tb_clock_gen #(
        .CLOCK_PERIOD (CLOCK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .o_clock      (clock),
        .o_soft_reset (soft_reset)
    );

    fetch_debug_top #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) dut (
        .i_clock         (clock),
        .i_soft_reset    (soft_reset),
        .i_command_valid (command_valid),
        .i_command       (command),
        .i_load_enable   (load_enable),
        .i_load_addr     (load_addr),
        .i_load_data     (load_data),
        .o_debug_data    (debug_data),
        .o_debug_valid   (debug_valid)
    );

    function automatic int random_between(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic fetch_state_t empty_snapshot();
        fetch_state_t s;
        s = '0;
        s.next_pc = PC_WIDTH'(4);
        return s;
    endfunction

    // What the database would capture from the model right now
    function automatic fetch_state_t model_live_state();
        fetch_state_t s;
        s.pc          = model_pc;
        s.next_pc     = model_pc + PC_WIDTH'(4);
        s.instruction = model_mem[MEM_ADDR_BITS'(model_pc >> 2)];
        s.cycle_count = model_count;
        return s;
    endfunction

    function automatic db_op_e command_to_db_op(input debug_cmd_e cmd);
        case (cmd)
            cmd_snapshot:     return db_capture;
            cmd_clear:        return db_clear;
            cmd_read_pc:      return db_read_pc;
            cmd_read_next_pc: return db_read_next_pc;
            cmd_read_instr:   return db_read_instr;
            cmd_read_cycles:  return db_read_cycles;
            default:          return db_hold;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks and reporting
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic report_error(input string msg);
        $display("error in %s: %s", current_test, msg);
        test_errors++;
    endtask

    task automatic compare_word(input logic [WORD_WIDTH-1:0] expected,
                                input logic [WORD_WIDTH-1:0] actual);
        checks_done++;
        if (actual !== expected) begin
            $display("mismatch %s: data expected %h, actual %h", current_test, expected, actual);
            test_errors++;
        end
    endtask

    task automatic compare_valid(input logic expected, input logic actual);
        checks_done++;
        if (actual !== expected) begin
            $display("mismatch %s: valid expected %0b, actual %0b", current_test, expected, actual);
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        current_test = name;
        test_errors  = 0;
    endtask

    task automatic report_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: PASS", current_test);
        end
        else begin
            tests_failed++;
            $display("%s: FAIL with %0d errors", current_test, test_errors);
        end
    endtask

    // Outputs seen at the falling edge come from the previous rising edge
    task automatic check_outputs();
        logic                  expect_valid;
        logic [WORD_WIDTH-1:0] expect_data;
        expect_valid = (expected_reads.size() != 0);
        compare_valid(expect_valid, debug_valid);
        if (debug_valid) begin
            read_pulses++;
        end
        if (expect_valid) begin
            expect_data = expected_reads.pop_front();
            if (debug_valid) begin
                compare_word(expect_data, debug_data);
            end
        end
        else begin
            // Between reads the output keeps the last result, or zero after a clear
            compare_word(model_data, debug_data);
        end
    endtask

    // One rising edge of the model, using the inputs just driven
    task automatic model_edge();
        fetch_state_t live;
        logic         fetch;
        live  = model_live_state();
        fetch = model_running || model_step;
        // The database acts on the opcode registered at the previous edge
        case (model_db_op)
            db_capture: model_snapshot = live;
            db_read_pc: begin
                model_data = WORD_WIDTH'(model_snapshot.pc);
                expected_reads.push_back(model_data);
            end
            db_read_next_pc: begin
                model_data = WORD_WIDTH'(model_snapshot.next_pc);
                expected_reads.push_back(model_data);
            end
            db_read_instr: begin
                model_data = model_snapshot.instruction;
                expected_reads.push_back(model_data);
            end
            db_read_cycles: begin
                model_data = WORD_WIDTH'(model_snapshot.cycle_count);
                expected_reads.push_back(model_data);
            end
            db_clear: begin
                model_snapshot = empty_snapshot();
                model_data     = '0;
            end
            default: ;
        endcase
        if (fetch) begin
            model_pc    = model_pc + PC_WIDTH'(4);
            model_count = model_count + PC_WIDTH'(1);
        end
        if (load_enable) begin
            model_mem[load_addr] = load_data;
        end
        model_step  = 1'b0;
        model_db_op = db_hold;
        if (command_valid) begin
            model_db_op = command_to_db_op(command);
            if (command == cmd_run) begin
                model_running = 1'b1;
            end
            else if (command == cmd_halt) begin
                model_running = 1'b0;
            end
            else if (command == cmd_step) begin
                model_step = !model_running;
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic tick(input logic valid, input debug_cmd_e cmd, input logic load_en,
                        input logic [MEM_ADDR_BITS-1:0] addr,
                        input logic [WORD_WIDTH-1:0] data);
        @(negedge clock);
        check_outputs();
        command_valid = valid;
        command       = cmd;
        load_enable   = load_en;
        load_addr     = addr;
        load_data     = data;
        model_edge();
    endtask

    task automatic idle_tick();
        tick(1'b0, cmd_nop, 1'b0, '0, '0);
    endtask

    task automatic send_command(input debug_cmd_e cmd);
        tick(1'b1, cmd, 1'b0, '0, '0);
    endtask

    task automatic load_word(input logic [MEM_ADDR_BITS-1:0] addr,
                             input logic [WORD_WIDTH-1:0] data);
        tick(1'b0, cmd_nop, 1'b1, addr, data);
    endtask

    // Read data lands two edges after its strobe and is checked on the way
    task automatic settle();
        int waited;
        waited = 0;
        while ((model_db_op != db_hold || expected_reads.size() != 0) && waited < 4) begin
            idle_tick();
            waited++;
        end
    endtask

    task automatic read_all_fields();
        send_command(cmd_read_pc);
        send_command(cmd_read_next_pc);
        send_command(cmd_read_instr);
        send_command(cmd_read_cycles);
    endtask

    task automatic run_for(input int cycles);
        send_command(cmd_run);
        repeat (cycles - 1) idle_tick();
        send_command(cmd_halt);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic load_and_step();
        int steps;
        start_test("load_and_step");
        for (int i = 0; i < MEM_DEPTH; i++) begin
            load_word(MEM_ADDR_BITS'(i), $random(seed));
        end
        steps = random_between(1, MAX_STEPS);
        // PC ends at 4 * steps and the instruction is the word loaded there
        repeat (steps) send_command(cmd_step);
        send_command(cmd_snapshot);
        send_command(cmd_read_instr);
        send_command(cmd_read_pc);
        settle();
        report_test();
    endtask

    task automatic run_halt_count();
        start_test("run_halt_count");
        run_for(random_between(1, MAX_RUN));
        send_command(cmd_snapshot);
        send_command(cmd_read_cycles);
        send_command(cmd_read_next_pc);
        settle();
        report_test();
    endtask

    task automatic snapshot_isolation();
        start_test("snapshot_isolation");
        send_command(cmd_snapshot);
        run_for(random_between(1, MAX_RUN));
        read_all_fields();
        settle();
        report_test();
    endtask

    task automatic clear_snapshot();
        start_test("clear_snapshot");
        send_command(cmd_clear);
        read_all_fields();
        settle();
        send_command(cmd_snapshot);
        send_command(cmd_read_pc);
        settle();
        report_test();
    endtask

    task automatic back_to_back_reads();
        int pulses_before;
        start_test("back_to_back_reads");
        send_command(cmd_step);
        send_command(cmd_step);
        send_command(cmd_snapshot);
        pulses_before = read_pulses;
        read_all_fields();
        settle();
        if (read_pulses - pulses_before != 4) begin
            report_error($sformatf("four read results expected, %0d came back",
                                   read_pulses - pulses_before));
        end
        report_test();
    endtask

    task automatic random_mix();
        int choice;
        start_test("random_mix");
        repeat (RANDOM_OPS) begin
            choice = random_between(0, 9);
            case (choice)
                0: send_command(cmd_run);
                1: send_command(cmd_halt);
                2: send_command(cmd_step);
                3: send_command(cmd_snapshot);
                4: send_command(cmd_clear);
                5: send_command(cmd_read_pc);
                6: send_command(cmd_read_next_pc);
                7: send_command(cmd_read_instr);
                8: send_command(cmd_read_cycles);
                default: begin
                    if (!model_running) begin
                        load_word(MEM_ADDR_BITS'(random_between(0, MEM_DEPTH - 1)),
                                  $random(seed));
                    end
                    else begin
                        idle_tick();
                    end
                end
            endcase
            repeat (random_between(0, 3)) idle_tick();
        end
        send_command(cmd_halt);
        settle();
        report_test();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequence and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        seed           = 20;
        command_valid  = 1'b0;
        command        = cmd_nop;
        load_enable    = 1'b0;
        load_addr      = '0;
        load_data      = '0;
        model_pc       = '0;
        model_count    = '0;
        model_running  = 1'b0;
        model_step     = 1'b0;
        model_db_op    = db_hold;
        model_snapshot = empty_snapshot();
        model_data     = '0;
        total_errors   = 0;
        tests_run      = 0;
        tests_failed   = 0;
        checks_done    = 0;
        read_pulses    = 0;
        wait (soft_reset == 1'b1);
        load_and_step();
        run_halt_count();
        snapshot_isolation();
        clear_snapshot();
        back_to_back_reads();
        random_mix();
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks_done, total_errors);
        if (total_errors == 0) begin
            $display("All tests passed!");
        end
        else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Timeout: the test sequence did not finish within %0d cycles",
                 WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

/* all.f */
verilog/fetch_debug_pkg.sv
verilog/instruction_memory.sv
verilog/fetch_stage.sv
verilog/debug_controller.sv
verilog/fetch_database.sv
verilog/fetch_debug_top.sv
tb/tb_clock_gen.sv
tb/fetch_debug_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the fetch debug testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
TOP=fetch_debug_tb

verilator --binary --timing --assert -j 0 \
    --top-module "$TOP" \
    --Mdir "$BUILD_DIR" \
    -f all.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator compilation failed with status $status"
    exit 1
fi

output=$("./$BUILD_DIR/V$TOP")
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx 'All tests passed!'; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
